// ==== common/bk_io_settings.svh ====
`ifndef BK_IO_SETTINGS_SVH
`define BK_IO_SETTINGS_SVH

//////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////

// System register, keyboard status and speaker
`define BK_SYSREG_ADDR 16'o177716

// Parallel port, joystick, mouse or Covox
`define BK_PORT_ADDR 16'o177714

// High byte returned by the system register
`define BK_START_ADDR 8'o200

//////////////////////////////////////////////////
// Mouse movement thresholds
//////////////////////////////////////////////////

// Positive move must be larger than this
`define BK_MOUSE_THRESH_POS 3

// Inverted negative move must be larger than this
`define BK_MOUSE_THRESH_NEG 2

//////////////////////////////////////////////////
// Audio scaling
//////////////////////////////////////////////////

`define BK_SPK_SHIFT 5
`define BK_AUDIO_PAD 6

`endif

// ==== common/bk_io_pkg.sv ====
package bk_io_pkg;

	//////////////////////////////////////////////////
	// Bus side
	//////////////////////////////////////////////////

	// Wishbone data word
	typedef logic [15:0] bus_word_t;

	// Byte address as the CPU sees it
	typedef logic [15:0] bus_addr_t;

	// One select bit per byte lane
	typedef logic [1:0] byte_sel_t;

	// Register targets behind the slave
	typedef enum logic [1:0] {
		none   = 2'd0,
		sysreg = 2'd1,
		port   = 2'd2
	} reg_target_e;

	//////////////////////////////////////////////////
	// Audio side
	//////////////////////////////////////////////////

	// Speaker and tape output levels
	typedef logic [2:0] spk_bits_t;

	// One PSG channel
	typedef logic [7:0] psg_sample_t;

	// Internal sum, wide enough for 2*A + B + speaker
	typedef logic [9:0] mix_t;

	// Sample handed to the DAC
	typedef logic [15:0] audio_sample_t;

	//////////////////////////////////////////////////
	// Pointer side
	//////////////////////////////////////////////////

	// Toggle, Y move, X move, signs and buttons
	typedef logic [24:0] ps2_mouse_t;

	// Direction latches in 3:0, buttons in 6:5
	typedef logic [6:0] pointer_state_t;

endpackage

// ==== logic/bk_bus_regs.sv ====
`timescale 1ns/1ps
`include "bk_io_settings.svh"

module bk_bus_regs (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 covox_en,
	input  logic                 model_bk0010,
	input  logic                 key_down,
	input  logic                 key_stop,

	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  bk_io_pkg::bus_addr_t wb_adr,
	input  bk_io_pkg::byte_sel_t wb_sel,
	input  bk_io_pkg::bus_word_t wb_dat_w,

	input  bk_io_pkg::bus_word_t pointer_word,

	output logic                 wb_ack,
	output bk_io_pkg::bus_word_t wb_dat_r,

	output logic                 stop_irq,
	output bk_io_pkg::spk_bits_t spk,
	output bk_io_pkg::bus_word_t covox_data,
	output logic                 port_wr_pulse,
	output logic [7:0]           port_wr_data
);

	localparam bk_io_pkg::bus_addr_t sysreg_addr = `BK_SYSREG_ADDR;
	localparam bk_io_pkg::bus_addr_t port_addr   = `BK_PORT_ADDR;

	bk_io_pkg::reg_target_e addr_target;
	bk_io_pkg::reg_target_e ack_target;
	logic                   access;
	logic                   sysreg_acc;
	logic                   sysreg_wr;
	logic                   port_wr;
	logic                   super_flg;
	logic                   stop_block;
	bk_io_pkg::bus_word_t   sysreg_value;

	//////////////////////////////////////////////////
	// Decode and handshake
	//////////////////////////////////////////////////

	// Bit 0 only picks the byte, lanes come from wb_sel
	always_comb begin
		addr_target = bk_io_pkg::none;
		if (wb_adr[15:1] == sysreg_addr[15:1]) begin
			addr_target = bk_io_pkg::sysreg;
		end else if (wb_adr[15:1] == port_addr[15:1]) begin
			addr_target = bk_io_pkg::port;
		end
	end

	// The ack cycle itself must not start a second access
	assign access     = wb_cyc & wb_stb & ~wb_ack & (addr_target != bk_io_pkg::none);
	assign sysreg_acc = access & (addr_target == bk_io_pkg::sysreg);
	assign sysreg_wr  = sysreg_acc & wb_we;
	assign port_wr    = access & (addr_target == bk_io_pkg::port) & wb_we;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ack_target <= bk_io_pkg::none;
		end else if (access) begin
			ack_target <= addr_target;
		end else begin
			ack_target <= bk_io_pkg::none;
		end
	end

	assign wb_ack = (ack_target != bk_io_pkg::none);

	//////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////

	// Supervisor bit shows the previous access type
	assign sysreg_value = {`BK_START_ADDR, 1'b1, ~key_down, 3'b000, super_flg, 2'b00};

	always_ff @(posedge clk_sys) begin
		if (access) begin
			case (addr_target)
				bk_io_pkg::sysreg: wb_dat_r <= sysreg_value;
				bk_io_pkg::port:   wb_dat_r <= pointer_word;
				default:           wb_dat_r <= '0;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Write side state
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			spk        <= '0;
			stop_block <= 1'b0;
			super_flg  <= 1'b0;
			covox_data <= '0;
		end else begin
			if (sysreg_acc) begin
				super_flg <= wb_we;
			end

			// Bit 11 set in the high byte means this write is not for us
			if (sysreg_wr && wb_sel[0] && (!wb_sel[1] || !wb_dat_w[11])) begin
				spk <= {wb_dat_w[6], wb_dat_w[5], wb_dat_w[2] & ~model_bk0010};
			end

			if (sysreg_wr && wb_sel[1] && !wb_dat_w[11]) begin
				stop_block <= wb_dat_w[12];
			end

			if (port_wr && covox_en) begin
				if (wb_sel[0]) begin
					covox_data[7:0] <= wb_dat_w[7:0];
				end
				if (wb_sel[1]) begin
					covox_data[15:8] <= wb_dat_w[15:8];
				end
			end
		end
	end

	assign stop_irq = key_stop & ~stop_block;

	// Port writes go to the mouse logic only when Covox is off
	assign port_wr_pulse = port_wr & ~covox_en & wb_sel[0];
	assign port_wr_data  = wb_dat_w[7:0];

endmodule

// ==== logic/bk_pointer_port.sv ====
`timescale 1ns/1ps
`include "bk_io_settings.svh"

module bk_pointer_port (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      covox_en,
	input  bk_io_pkg::bus_word_t      joystick_0,
	input  bk_io_pkg::bus_word_t      joystick_1,
	input  bk_io_pkg::ps2_mouse_t     ps2_mouse,
	input  logic                      port_wr_pulse,
	input  logic [7:0]                port_wr_data,
	output bk_io_pkg::bus_word_t      pointer_word
);

	bk_io_pkg::ps2_mouse_t     mouse_q;
	logic                      toggle_q;
	logic                      packet_new;
	logic [8:0]                move_x;
	logic [8:0]                move_y;
	logic [8:0]                inv_x;
	logic [8:0]                inv_y;
	logic                      mouse_en;
	logic                      mouse_sel;
	bk_io_pkg::pointer_state_t mouse_state;
	bk_io_pkg::bus_word_t      joystick;

	//////////////////////////////////////////////////
	// Packet sampling
	//////////////////////////////////////////////////

	// Packet is captured first and compared a cycle later
	always_ff @(posedge clk_sys) begin
		mouse_q  <= ps2_mouse;
		toggle_q <= mouse_q[24];
	end

	assign packet_new = (toggle_q != mouse_q[24]);

	// Sign bit on top of the 8-bit move
	assign move_x = {mouse_q[4], mouse_q[15:8]};
	assign move_y = {mouse_q[5], mouse_q[23:16]};

	// Inverted moves kept at 9 bits for the negative threshold
	assign inv_x = ~move_x;
	assign inv_y = ~move_y;

	assign joystick = joystick_0 | joystick_1;

	//////////////////////////////////////////////////
	// Port image
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mouse_en    <= 1'b0;
			mouse_sel   <= 1'b0;
			mouse_state <= '0;
		end else begin
			// Any joystick activity takes the port back
			if (|joystick) begin
				mouse_sel <= 1'b0;
			end

			if (port_wr_pulse) begin
				mouse_en <= port_wr_data[3];
				if (!port_wr_data[3]) begin
					mouse_state[3:0] <= '0;
				end
			end

			if (packet_new) begin
				mouse_state[6] <= mouse_q[1];
				mouse_state[5] <= mouse_q[0];
				mouse_sel      <= 1'b1;
				if (mouse_en) begin
					// Direction bits latch until software clears them
					if (!mouse_state[0] && !mouse_state[2]) begin
						if (!move_y[8] && (move_y > `BK_MOUSE_THRESH_POS)) begin
							mouse_state[0] <= 1'b1;
						end
						if (move_y[8] && (inv_y > `BK_MOUSE_THRESH_NEG)) begin
							mouse_state[2] <= 1'b1;
						end
					end
					if (!mouse_state[1] && !mouse_state[3]) begin
						if (!move_x[8] && (move_x > `BK_MOUSE_THRESH_POS)) begin
							mouse_state[1] <= 1'b1;
						end
						if (move_x[8] && (inv_x > `BK_MOUSE_THRESH_NEG)) begin
							mouse_state[3] <= 1'b1;
						end
					end
				end
			end
		end
	end

	assign pointer_word = (mouse_sel && !covox_en) ? bk_io_pkg::bus_word_t'(mouse_state) :
		joystick;

endmodule

// ==== logic/bk_audio_mixer.sv ====
`timescale 1ns/1ps
`include "bk_io_settings.svh"

module bk_audio_mixer (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      covox_en,
	input  bk_io_pkg::spk_bits_t      spk,
	input  bk_io_pkg::bus_word_t      covox_data,
	input  bk_io_pkg::psg_sample_t    psg_a,
	input  bk_io_pkg::psg_sample_t    psg_b,
	input  bk_io_pkg::psg_sample_t    psg_c,
	input  logic [5:0]                psg_active,
	output bk_io_pkg::audio_sample_t  audio_l,
	output bk_io_pkg::audio_sample_t  audio_r
);

	bk_io_pkg::mix_t spk_term;
	bk_io_pkg::mix_t spk_only;
	bk_io_pkg::mix_t mix_l;
	bk_io_pkg::mix_t mix_r;

	// Twice the main source plus a side source plus speaker
	function automatic bk_io_pkg::mix_t mix_chan(
		input bk_io_pkg::psg_sample_t doubled,
		input bk_io_pkg::psg_sample_t added,
		input bk_io_pkg::mix_t        speaker
	);
		return {1'b0, doubled, 1'b0} + {2'b00, added} + speaker;
	endfunction

	assign spk_term = bk_io_pkg::mix_t'(spk) << `BK_SPK_SHIFT;

	// Speaker alone gets the full range
	assign spk_only = bk_io_pkg::mix_t'(spk) << (`BK_SPK_SHIFT + 2);

	always_comb begin
		if (covox_en) begin
			mix_l = mix_chan(covox_data[7:0], 8'd0, spk_term);
			mix_r = mix_chan(covox_data[15:8], 8'd0, spk_term);
		end else if (psg_active != '0) begin
			// Channel B sits in the middle
			mix_l = mix_chan(psg_a, psg_b, spk_term);
			mix_r = mix_chan(psg_c, psg_b, spk_term);
		end else begin
			mix_l = spk_only;
			mix_r = spk_only;
		end
	end

	//////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= {mix_l, {`BK_AUDIO_PAD{1'b0}}};
			audio_r <= {mix_r, {`BK_AUDIO_PAD{1'b0}}};
		end
	end

endmodule

// ==== logic/bk_io_top.sv ====
`timescale 1ns/1ps

module bk_io_top (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      covox_en,
	input  logic                      model_bk0010,
	input  logic                      key_down,
	input  logic                      key_stop,

	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_we,
	input  bk_io_pkg::bus_addr_t      wb_adr,
	input  bk_io_pkg::byte_sel_t      wb_sel,
	input  bk_io_pkg::bus_word_t      wb_dat_w,
	output logic                      wb_ack,
	output bk_io_pkg::bus_word_t      wb_dat_r,

	input  bk_io_pkg::bus_word_t      joystick_0,
	input  bk_io_pkg::bus_word_t      joystick_1,
	input  bk_io_pkg::ps2_mouse_t     ps2_mouse,

	input  bk_io_pkg::psg_sample_t    psg_a,
	input  bk_io_pkg::psg_sample_t    psg_b,
	input  bk_io_pkg::psg_sample_t    psg_c,
	input  logic [5:0]                psg_active,

	output logic                      stop_irq,
	output bk_io_pkg::audio_sample_t  audio_l,
	output bk_io_pkg::audio_sample_t  audio_r
);

	bk_io_pkg::bus_word_t pointer_word;
	bk_io_pkg::bus_word_t covox_data;
	bk_io_pkg::spk_bits_t spk;
	logic                 port_wr_pulse;
	logic [7:0]           port_wr_data;

	// Register block, the bus faces this one
	bk_bus_regs bk_bus_regs_inst (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.covox_en      (covox_en),
		.model_bk0010  (model_bk0010),
		.key_down      (key_down),
		.key_stop      (key_stop),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_sel        (wb_sel),
		.wb_dat_w      (wb_dat_w),
		.pointer_word  (pointer_word),
		.wb_ack        (wb_ack),
		.wb_dat_r      (wb_dat_r),
		.stop_irq      (stop_irq),
		.spk           (spk),
		.covox_data    (covox_data),
		.port_wr_pulse (port_wr_pulse),
		.port_wr_data  (port_wr_data)
	);

	bk_pointer_port bk_pointer_port_inst (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.covox_en      (covox_en),
		.joystick_0    (joystick_0),
		.joystick_1    (joystick_1),
		.ps2_mouse     (ps2_mouse),
		.port_wr_pulse (port_wr_pulse),
		.port_wr_data  (port_wr_data),
		.pointer_word  (pointer_word)
	);

	bk_audio_mixer bk_audio_mixer_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.covox_en   (covox_en),
		.spk        (spk),
		.covox_data (covox_data),
		.psg_a      (psg_a),
		.psg_b      (psg_b),
		.psg_c      (psg_c),
		.psg_active (psg_active),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

endmodule

// ==== verification/bk_io_tb.sv ====
`timescale 1ns/1ps
`include "bk_io_settings.svh"

module bk_io_tb;

	typedef enum logic [2:0] {op_write, op_read, op_mouse, op_joy, op_settle} op_e;
	typedef enum logic [1:0] {chk_none, chk_word, chk_audio, chk_stop} check_e;

	// One table row with the mouse packet or joystick_1 in aux
	typedef struct packed {
		op_e                      op;
		check_e                   check;
		bk_io_pkg::reg_target_e   target;
		bk_io_pkg::bus_word_t     data;
		bk_io_pkg::byte_sel_t     sel;
		logic                     covox_en;
		logic                     model_bk0010;
		logic                     key_down;
		logic                     key_stop;
		logic [5:0]               psg_active;
		bk_io_pkg::psg_sample_t   psg_a;
		bk_io_pkg::psg_sample_t   psg_b;
		bk_io_pkg::psg_sample_t   psg_c;
		bk_io_pkg::ps2_mouse_t    aux;
		bk_io_pkg::bus_word_t     exp_word;
		bk_io_pkg::audio_sample_t exp_l;
		bk_io_pkg::audio_sample_t exp_r;
		logic                     exp_bit;
	} row_t;

	logic                     clk_sys;
	logic                     rst_n;
	logic                     covox_en;
	logic                     model_bk0010;
	logic                     key_down;
	logic                     key_stop;
	logic                     wb_cyc;
	logic                     wb_stb;
	logic                     wb_we;
	bk_io_pkg::bus_addr_t     wb_adr;
	bk_io_pkg::byte_sel_t     wb_sel;
	bk_io_pkg::bus_word_t     wb_dat_w;
	logic                     wb_ack;
	bk_io_pkg::bus_word_t     wb_dat_r;
	bk_io_pkg::bus_word_t     joystick_0;
	bk_io_pkg::bus_word_t     joystick_1;
	bk_io_pkg::ps2_mouse_t    ps2_mouse;
	bk_io_pkg::psg_sample_t   psg_a;
	bk_io_pkg::psg_sample_t   psg_b;
	bk_io_pkg::psg_sample_t   psg_c;
	logic [5:0]               psg_active;
	logic                     stop_irq;
	bk_io_pkg::audio_sample_t audio_l;
	bk_io_pkg::audio_sample_t audio_r;

	row_t  rows[$];
	string names[$];
	row_t  side;
	logic  mouse_toggle;
	int    errors;
	int    checks;
	int    cycle_count;
	int    cycle_limit;

	bk_io_top bk_io_top_inst (.*);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Run stopped after %0d cycles, the table did not finish", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Expected values
	//////////////////////////////////////////////////

	function automatic bk_io_pkg::audio_sample_t pad_mix(input int mix);
		return bk_io_pkg::audio_sample_t'(mix << `BK_AUDIO_PAD);
	endfunction

	// Speaker alone with no PSG and no Covox
	function automatic bk_io_pkg::audio_sample_t speaker_sample(
		input bk_io_pkg::spk_bits_t level);
		return pad_mix(int'(level) << (`BK_SPK_SHIFT + 2));
	endfunction

	function automatic bk_io_pkg::audio_sample_t mix_sample(
		input bk_io_pkg::psg_sample_t doubled,
		input bk_io_pkg::psg_sample_t added, input bk_io_pkg::spk_bits_t level);
		return pad_mix(2 * int'(doubled) + int'(added) + (int'(level) << `BK_SPK_SHIFT));
	endfunction

	function automatic bk_io_pkg::bus_word_t sysreg_word(input logic kd, input logic super_flg);
		bk_io_pkg::bus_word_t word;
		word = {`BK_START_ADDR, 8'h80};
		if (!kd) begin
			word[6] = 1'b1;
		end
		if (super_flg) begin
			word[2] = 1'b1;
		end
		return word;
	endfunction

	function automatic bk_io_pkg::ps2_mouse_t mouse_packet(input int dy, input int dx,
		input logic [1:0] buttons);
		bk_io_pkg::ps2_mouse_t pkt;
		pkt = '0;
		pkt[23:16] = dy[7:0];
		pkt[15:8] = dx[7:0];
		pkt[5] = (dy < 0);
		pkt[4] = (dx < 0);
		pkt[1:0] = buttons;
		return pkt;
	endfunction

	function automatic bk_io_pkg::bus_addr_t target_addr(input bk_io_pkg::reg_target_e target);
		return (target == bk_io_pkg::port) ? `BK_PORT_ADDR : `BK_SYSREG_ADDR;
	endfunction

	//////////////////////////////////////////////////
	// Table building
	//////////////////////////////////////////////////

	task automatic set_side(input logic cov, input logic model, input logic kd, input logic ks);
		side = '0;
		side.covox_en = cov;
		side.model_bk0010 = model;
		side.key_down = kd;
		side.key_stop = ks;
	endtask

	task automatic push_row(input string name, input op_e op,
		input bk_io_pkg::reg_target_e target, input bk_io_pkg::bus_word_t data,
		input bk_io_pkg::byte_sel_t sel);
		row_t r;
		r = side;
		r.op = op;
		r.check = chk_none;
		r.target = target;
		r.data = data;
		r.sel = sel;
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic expect_word(input bk_io_pkg::bus_word_t value);
		int last;
		last = rows.size() - 1;
		rows[last].check = chk_word;
		rows[last].exp_word = value;
	endtask

	task automatic expect_audio(input bk_io_pkg::audio_sample_t l,
		input bk_io_pkg::audio_sample_t r);
		int last;
		last = rows.size() - 1;
		rows[last].check = chk_audio;
		rows[last].exp_l = l;
		rows[last].exp_r = r;
	endtask

	task automatic expect_stop(input logic value);
		int last;
		last = rows.size() - 1;
		rows[last].check = chk_stop;
		rows[last].exp_bit = value;
	endtask

	task automatic psg_row(input string name, input bk_io_pkg::spk_bits_t level);
		bk_io_pkg::psg_sample_t a;
		bk_io_pkg::psg_sample_t b;
		bk_io_pkg::psg_sample_t c;
		int last;
		a = bk_io_pkg::psg_sample_t'($urandom);
		b = bk_io_pkg::psg_sample_t'($urandom);
		c = bk_io_pkg::psg_sample_t'($urandom);
		push_row(name, op_settle, bk_io_pkg::none, '0, '0);
		last = rows.size() - 1;
		rows[last].psg_active = 6'($urandom % 63 + 1);
		rows[last].psg_a = a;
		rows[last].psg_b = b;
		rows[last].psg_c = c;
		expect_audio(mix_sample(a, b, level), mix_sample(c, b, level));
	endtask

	task automatic mouse_row(input string name, input int dy, input int dx, input logic [1:0] btn);
		push_row(name, op_mouse, bk_io_pkg::none, '0, '0);
		rows[rows.size() - 1].aux = mouse_packet(dy, dx, btn);
	endtask

	task automatic joy_row(input string name, input bk_io_pkg::bus_word_t j0,
		input bk_io_pkg::bus_word_t j1);
		push_row(name, op_joy, bk_io_pkg::none, j0, '0);
		rows[rows.size() - 1].aux = bk_io_pkg::ps2_mouse_t'(j1);
	endtask

	task automatic build_table();
		bk_io_pkg::bus_word_t cov_w [3];
		for (int k = 0; k < 3; k++) begin
			cov_w[k] = bk_io_pkg::bus_word_t'($urandom);
		end

		// Read value, supervisor flag and speaker bits
		set_side(1'b0, 1'b0, 1'b1, 1'b0);
		push_row("sysreg read after reset", op_read, bk_io_pkg::sysreg, '0, 2'b11);
		expect_word(sysreg_word(1'b1, 1'b0));
		set_side(1'b0, 1'b0, 1'b0, 1'b0);
		push_row("speaker write bk0011", op_write, bk_io_pkg::sysreg, 16'h0064, 2'b01);
		expect_audio(speaker_sample(3'b111), speaker_sample(3'b111));
		push_row("sysreg read after write", op_read, bk_io_pkg::sysreg, '0, 2'b11);
		expect_word(sysreg_word(1'b0, 1'b1));
		push_row("sysreg read after read", op_read, bk_io_pkg::sysreg, '0, 2'b11);
		expect_word(sysreg_word(1'b0, 1'b0));
		set_side(1'b0, 1'b1, 1'b0, 1'b0);
		push_row("speaker write bk0010", op_write, bk_io_pkg::sysreg, 16'h0064, 2'b01);
		expect_audio(speaker_sample(3'b110), speaker_sample(3'b110));
		set_side(1'b0, 1'b0, 1'b0, 1'b0);
		push_row("word write with bit 11", op_write, bk_io_pkg::sysreg, 16'h0804, 2'b11);
		expect_audio(speaker_sample(3'b110), speaker_sample(3'b110));

		// Stop key blocking
		set_side(1'b0, 1'b0, 1'b0, 1'b1);
		push_row("stop key open", op_settle, bk_io_pkg::none, '0, '0);
		expect_stop(1'b1);
		push_row("stop block set", op_write, bk_io_pkg::sysreg, 16'h1000, 2'b10);
		expect_stop(1'b0);
		push_row("stop write with bit 11", op_write, bk_io_pkg::sysreg, 16'h0800, 2'b11);
		expect_stop(1'b0);
		push_row("stop block clear", op_write, bk_io_pkg::sysreg, 16'h0000, 2'b10);
		expect_stop(1'b1);

		// Covox lanes over speaker level 2
		set_side(1'b0, 1'b0, 1'b0, 1'b0);
		push_row("speaker level 2", op_write, bk_io_pkg::sysreg, 16'h0020, 2'b01);
		expect_audio(speaker_sample(3'b010), speaker_sample(3'b010));
		set_side(1'b1, 1'b0, 1'b0, 1'b0);
		push_row("covox low lane", op_write, bk_io_pkg::port, cov_w[0], 2'b01);
		expect_audio(mix_sample(cov_w[0][7:0], 8'd0, 3'b010), mix_sample(8'd0, 8'd0, 3'b010));
		push_row("covox high lane", op_write, bk_io_pkg::port, cov_w[1], 2'b10);
		expect_audio(mix_sample(cov_w[0][7:0], 8'd0, 3'b010),
			mix_sample(cov_w[1][15:8], 8'd0, 3'b010));
		push_row("covox low lane again", op_write, bk_io_pkg::port, cov_w[2], 2'b01);
		expect_audio(mix_sample(cov_w[2][7:0], 8'd0, 3'b010),
			mix_sample(cov_w[1][15:8], 8'd0, 3'b010));

		// PSG channels
		set_side(1'b0, 1'b0, 1'b0, 1'b0);
		psg_row("psg mix 1", 3'b010);
		psg_row("psg mix 2", 3'b010);
		psg_row("psg mix 3", 3'b010);
		push_row("psg idle", op_settle, bk_io_pkg::none, '0, '0);
		expect_audio(speaker_sample(3'b010), speaker_sample(3'b010));

		// Mouse latches with buttons in 6:5 and directions in 3:0
		push_row("mouse enable", op_write, bk_io_pkg::port, 16'h0008, 2'b01);
		mouse_row("packet y+5 x+2 left", 5, 2, 2'b01);
		push_row("port read y up", op_read, bk_io_pkg::port, '0, 2'b11);
		expect_word(16'h0021);
		mouse_row("packet y-4 x-4", -4, -4, 2'b00);
		push_row("port read x latched", op_read, bk_io_pkg::port, '0, 2'b11);
		expect_word(16'h0009);
		push_row("mouse clear", op_write, bk_io_pkg::port, 16'h0000, 2'b01);
		push_row("mouse enable again", op_write, bk_io_pkg::port, 16'h0008, 2'b01);
		mouse_row("packet y-3 x+2", -3, 2, 2'b00);
		push_row("port read below threshold", op_read, bk_io_pkg::port, '0, 2'b11);
		expect_word(16'h0000);
		mouse_row("packet y-4 x+5 right", -4, 5, 2'b10);
		push_row("port read after clear", op_read, bk_io_pkg::port, '0, 2'b11);
		expect_word(16'h0046);
		joy_row("joystick press", 16'h0010, 16'h0201);
		push_row("port read joystick", op_read, bk_io_pkg::port, '0, 2'b11);
		expect_word(16'h0211);
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input bk_io_pkg::bus_word_t expected,
		input bk_io_pkg::bus_word_t actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED at %0d ns: %s expected 16'h%h, got 16'h%h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_sample(input string name, input bk_io_pkg::audio_sample_t expected,
		input bk_io_pkg::audio_sample_t actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED at %0d ns: %s expected 16'h%h, got 16'h%h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Applying rows
	//////////////////////////////////////////////////

	// Holds the request until ack, then expects ack gone one cycle later
	task automatic bus_access(input row_t row, output bk_io_pkg::bus_word_t rdata);
		int   waited;
		logic acked;
		waited = 0;
		acked = 1'b0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = (row.op == op_write);
		wb_adr = target_addr(row.target);
		wb_sel = row.sel;
		wb_dat_w = row.data;
		while (!acked && waited < 4) begin
			@(negedge clk_sys);
			waited++;
			acked = wb_ack;
		end
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!acked) begin
			$display("No ack within 4 cycles for the access to address %o", wb_adr);
			errors++;
		end
		@(negedge clk_sys);
		if (wb_ack) begin
			$display("Ack stayed high for two cycles at %0d ns", $time);
			errors++;
		end
	endtask

	task automatic run_row(input int idx);
		row_t                 row;
		bk_io_pkg::bus_word_t rdata;
		int                   errors_before;
		row = rows[idx];
		rdata = '0;
		errors_before = errors;
		covox_en = row.covox_en;
		model_bk0010 = row.model_bk0010;
		key_down = row.key_down;
		key_stop = row.key_stop;
		psg_active = row.psg_active;
		psg_a = row.psg_a;
		psg_b = row.psg_b;
		psg_c = row.psg_c;
		case (row.op)
			op_write, op_read: bus_access(row, rdata);
			op_mouse: begin
				// New packet is seen through the toggle bit
				mouse_toggle = ~mouse_toggle;
				ps2_mouse = row.aux;
				ps2_mouse[24] = mouse_toggle;
				repeat (2) @(negedge clk_sys);
			end
			op_joy: begin
				joystick_0 = row.data;
				joystick_1 = row.aux[15:0];
			end
			default: begin
			end
		endcase
		@(negedge clk_sys);
		case (row.check)
			chk_word: check_word("wb_dat_r", row.exp_word, rdata);
			chk_audio: begin
				check_sample("audio_l", row.exp_l, audio_l);
				check_sample("audio_r", row.exp_r, audio_r);
			end
			chk_stop: check_bit("stop_irq", row.exp_bit, stop_irq);
			default: begin
			end
		endcase
		$display("row %0d %s: %s", idx, names[idx],
			(errors == errors_before) ? "ok" : "mismatch");
	endtask

	initial begin
		clk_sys = 1'b0;
		rst_n = 1'b0;
		covox_en = 1'b0;
		model_bk0010 = 1'b0;
		key_down = 1'b0;
		key_stop = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_sel = '0;
		wb_dat_w = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		ps2_mouse = '0;
		psg_a = '0;
		psg_b = '0;
		psg_c = '0;
		psg_active = '0;
		mouse_toggle = 1'b0;
		void'($urandom(30));
		build_table();
		cycle_limit = rows.size() * 20;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
		end
		$display("Rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== bk_io_top.f ====
+incdir+common
common/bk_io_pkg.sv
logic/bk_bus_regs.sv
logic/bk_pointer_port.sv
logic/bk_audio_mixer.sv
logic/bk_io_top.sv
verification/bk_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module bk_io_tb -f bk_io_top.f -o bk_io_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build returned status $status"
	exit 1
fi

./obj_dir/bk_io_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit 1
fi

# The run only counts when the pass line is in the log
if grep -qx "Test passed" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1
